//--- alu.sv
`include "cpu_macros.svh"

module alu
	import isaPkg::*;
	import corePkg::*;
(
	input  logic  clk,
	input  logic  arstN,
	input  logic  start,
	input  aluOpT op,
	input  wordT  a,
	input  wordT  b,
	input  logic  carryIn,
	output wordT  result,
	output flagsT flags,
	output logic  doneStrobe
);

	localparam int Msb = `CPU_WORD_W - 1;

	logic [`CPU_WORD_W:0] wide;    // top bit is carry or borrow
	logic [`CPU_WORD_W:0] cinWide;
	logic isSub;
	logic useCarry;
	logic ovf;

	always_comb begin
		isSub = (op == aluSub) || (op == aluSubCarry) || (op == aluCompare);
		useCarry = (op == aluAddCarry) || (op == aluSubCarry);
		cinWide = {{`CPU_WORD_W{1'b0}}, useCarry & carryIn};
		if (isSub) begin
			wide = {1'b0, a} - {1'b0, b} - cinWide;
			ovf = (a[Msb] != b[Msb]) && (wide[Msb] != a[Msb]);
		end else begin
			wide = {1'b0, a} + {1'b0, b} + cinWide;
			ovf = (a[Msb] == b[Msb]) && (wide[Msb] != a[Msb]);
		end
	end

	// result holds until the next start
	always_ff @(posedge clk) begin
		if (start) begin
			result <= wide[Msb:0];
			flags.carry <= wide[`CPU_WORD_W];
			flags.zero <= (wide[Msb:0] == '0);
			flags.overflow <= ovf;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			doneStrobe <= 1'b0;
		end else begin
			doneStrobe <= start;
		end
	end

	// the control unit waits out each operation before issuing another
	noBackToBack: assert property (@(posedge clk) disable iff (!arstN) doneStrobe |-> !start)
		else $error("alu start while previous result was completing");

endmodule

//--- controlUnit.sv
`include "cpu_macros.svh"

module controlUnit
	import isaPkg::*;
	import corePkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  logic   run,
	input  wordT   opcodeWord,
	input  wordT   par1Word,
	input  wordT   par2Word,
	output addrT   fetchAddr,
	memIf.ctrl     dataPort,
	output regSelT rdSelA,
	output regSelT rdSelB,
	input  wordT   rdDataA,
	input  wordT   rdDataB,
	output logic   wrEn,
	output regSelT wrSel,
	output wordT   wrData,
	output logic   aluStart,
	output aluOpT  aluOp,
	output logic   carryIn,
	input  wordT   aluResult,
	input  flagsT  aluFlags,
	input  logic   aluDone,
	output logic   halted,
	output wordT   outData,
	output logic   outValid
);

	ctrlStateT state;
	addrT pc;
	addrT sp;
	addrT pcNext;
	flagsT flags;
	opcodeT opcode;
	regSelT dstSel;
	regSelT srcSel;
	addrT par1Addr;
	addrT par2Addr;
	wordT logicResult;
	logic jumpTaken;
	logic aluInstr;
	logic memInstr;

	assign opcode = opcodeT'(opcodeWord);
	assign dstSel = regSelT'(par1Word[3:2]);
	assign srcSel = regSelT'(par1Word[1:0]); // also the single-register select
	assign par1Addr = par1Word[`CPU_ADDR_W-1:0];
	assign par2Addr = par2Word[`CPU_ADDR_W-1:0];

	// pc stays put until the instruction retires, so the fetched words stay valid
	assign fetchAddr = pc;
	assign rdSelA = dstSel;
	assign rdSelB = srcSel;
	assign carryIn = flags.carry;
	assign halted = (state == stHalted);

	assign aluInstr = opcode inside {opAdd, opAdc, opSub, opSuc, opCmp};
	assign memInstr = opcode inside {opLda, opPop, opRet, opPutc};

	always_comb begin
		case (opcode)
			opMovi, opLda, opSta: pcNext = pc + addrT'(3);
			opPop, opPush, opMovrr, opAdd, opAdc, opSub, opSuc, opCmp,
			opAnd, opInv, opOr, opShl, opShr, opXor, opTest, opCall, opPutc,
			opJmp, opJc, opJnc, opJz, opJnz, opJo, opJno: pcNext = pc + addrT'(2);
			default: pcNext = pc + addrT'(1); // nop, ret, halt and unknown opcodes
		endcase
	end

	always_comb begin
		case (opcode)
			opJmp, opCall: jumpTaken = 1'b1;
			opJc: jumpTaken = flags.carry;
			opJnc: jumpTaken = !flags.carry;
			opJz: jumpTaken = flags.zero;
			opJnz: jumpTaken = !flags.zero;
			opJo: jumpTaken = flags.overflow;
			opJno: jumpTaken = !flags.overflow;
			default: jumpTaken = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode)
			opAnd: logicResult = rdDataA & rdDataB;
			opOr: logicResult = rdDataA | rdDataB;
			opXor: logicResult = rdDataA ^ rdDataB;
			opInv: logicResult = ~rdDataB;
			opShl: logicResult = rdDataB << 1;
			opShr: logicResult = rdDataB >> 1;
			default: logicResult = rdDataB; // register move
		endcase
	end

	always_comb begin
		case (opcode)
			opAdc: aluOp = aluAddCarry;
			opSub: aluOp = aluSub;
			opSuc: aluOp = aluSubCarry;
			opCmp: aluOp = aluCompare;
			default: aluOp = aluAdd;
		endcase
	end

	assign aluStart = run && (state == stExecute) && aluInstr;

	// data port, address stays stable through memWait
	always_comb begin
		case (opcode)
			opSta, opLda: dataPort.addr = par2Addr;
			opPush, opCall: dataPort.addr = sp;
			opPop, opRet: dataPort.addr = sp - addrT'(1);
			default: dataPort.addr = par1Addr;
		endcase
	end

	assign dataPort.wdata = (opcode == opCall) ? wordT'(pcNext) : rdDataB;
	assign dataPort.we = run && (state == stExecute) && (opcode inside {opSta, opPush, opCall});

	assign outData = dataPort.rdata;
	assign outValid = run && (state == stMemWait) && (opcode == opPutc);

	always_comb begin
		wrEn = 1'b0;
		wrSel = dstSel;
		wrData = logicResult;
		if (run) begin
			case (state)
				stExecute: begin
					case (opcode)
						opMovrr, opAnd, opOr, opXor: wrEn = 1'b1;
						opInv, opShl, opShr: begin
							wrEn = 1'b1;
							wrSel = srcSel;
						end
						opMovi: begin
							wrEn = 1'b1;
							wrSel = srcSel;
							wrData = par2Word;
						end
						default: wrEn = 1'b0;
					endcase
				end
				stAluWait: begin
					wrEn = aluDone && (opcode != opCmp);
					wrData = aluResult;
				end
				stMemWait: begin
					wrEn = (opcode == opLda) || (opcode == opPop);
					wrSel = srcSel;
					wrData = dataPort.rdata;
				end
				default: wrEn = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stFetch;
			pc <= '0;
			sp <= `CPU_STACK_BASE;
			flags <= '0;
		end else if (run) begin
			case (state)
				stFetch: state <= stExecute; // words registered at fetchAddr
				stExecute: begin
					if (opcode == opHalt) begin
						state <= stHalted;
					end else if (aluInstr) begin
						state <= stAluWait;
					end else if (memInstr) begin
						state <= stMemWait;
					end else begin
						state <= stFetch;
						pc <= jumpTaken ? par1Addr : pcNext;
					end
					if (opcode == opPush || opcode == opCall) begin
						sp <= sp + addrT'(1);
					end
					if (opcode == opTest) begin
						flags.zero <= (rdDataA == rdDataB);
					end
				end
				stAluWait: begin
					if (aluDone) begin // result registered one cycle after start
						flags <= aluFlags;
						pc <= pcNext;
						state <= stFetch;
					end
				end
				stMemWait: begin
					if (opcode == opPop || opcode == opRet) begin
						sp <= sp - addrT'(1);
					end
					pc <= (opcode == opRet) ? dataPort.rdata[`CPU_ADDR_W-1:0] : pcNext;
					state <= stFetch;
				end
				default: state <= stHalted; // stays until reset
			endcase
		end
	end

	spInStack: assert property (@(posedge clk) disable iff (!arstN)
		sp >= addrT'(`CPU_STACK_BASE))
		else $error("stack pointer left the stack region");

endmodule

//--- corePkg.sv
package corePkg;

	// sequencing of one instruction
	typedef enum logic [2:0] {
		stFetch,
		stExecute,
		stAluWait,
		stMemWait,
		stHalted
	} ctrlStateT;

	typedef enum logic [2:0] {
		aluAdd,
		aluAddCarry,
		aluSub,
		aluSubCarry,
		aluCompare // same flags as sub, no writeback
	} aluOpT;

	typedef struct packed {
		logic carry;    // carry out, or borrow on subtract
		logic zero;
		logic overflow; // signed overflow
	} flagsT;

endpackage

//--- cpuTop.sv
module cpuTop
	import isaPkg::*;
	import corePkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic loadEn,
	input  addrT loadAddr,
	input  wordT loadData,
	input  logic run,
	output logic halted,
	output wordT outData,
	output logic outValid
);

	addrT fetchAddr;
	wordT opcodeWord;
	wordT par1Word;
	wordT par2Word;
	regSelT rdSelA;
	regSelT rdSelB;
	wordT rdDataA;
	wordT rdDataB;
	logic wrEn;
	regSelT wrSel;
	wordT wrData;
	logic aluStart;
	aluOpT aluOp;
	logic carryIn;
	wordT aluResult;
	flagsT aluFlags;
	logic aluDone;

	memIf dataBus ();

	progMem iProgMem (
		.clk        (clk),
		.loadEn     (loadEn),
		.loadAddr   (loadAddr),
		.loadData   (loadData),
		.fetchAddr  (fetchAddr),
		.opcodeWord (opcodeWord),
		.par1Word   (par1Word),
		.par2Word   (par2Word),
		.dataPort   (dataBus.mem)
	);

	regFile iRegFile (
		.clk     (clk),
		.arstN   (arstN),
		.rdSelA  (rdSelA),
		.rdSelB  (rdSelB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wrEn),
		.wrSel   (wrSel),
		.wrData  (wrData)
	);

	alu iAlu (
		.clk        (clk),
		.arstN      (arstN),
		.start      (aluStart),
		.op         (aluOp),
		.a          (rdDataA),
		.b          (rdDataB),
		.carryIn    (carryIn),
		.result     (aluResult),
		.flags      (aluFlags),
		.doneStrobe (aluDone)
	);

	controlUnit iControl (
		.clk        (clk),
		.arstN      (arstN),
		.run        (run),
		.opcodeWord (opcodeWord),
		.par1Word   (par1Word),
		.par2Word   (par2Word),
		.fetchAddr  (fetchAddr),
		.dataPort   (dataBus.ctrl),
		.rdSelA     (rdSelA),
		.rdSelB     (rdSelB),
		.rdDataA    (rdDataA),
		.rdDataB    (rdDataB),
		.wrEn       (wrEn),
		.wrSel      (wrSel),
		.wrData     (wrData),
		.aluStart   (aluStart),
		.aluOp      (aluOp),
		.carryIn    (carryIn),
		.aluResult  (aluResult),
		.aluFlags   (aluFlags),
		.aluDone    (aluDone),
		.halted     (halted),
		.outData    (outData),
		.outValid   (outValid)
	);

endmodule

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and instruction word width
`define CPU_WORD_W 16

// memory address width, addresses wrap at the top
`define CPU_ADDR_W 10

// number of words in the shared memory
`define CPU_MEM_DEPTH 1024

// stack occupies the top of memory and grows upward
`define CPU_STACK_BASE 10'h380

`endif

//--- isaPkg.sv
`include "cpu_macros.svh"

package isaPkg;

	typedef logic [`CPU_WORD_W-1:0] wordT;
	typedef logic [`CPU_ADDR_W-1:0] addrT;

	typedef enum logic [1:0] {
		regAx = 2'd0,
		regBx = 2'd1,
		regCx = 2'd2,
		regDx = 2'd3
	} regSelT;

	typedef enum logic [15:0] {
		opNop   = 16'h0000,
		opMovrr = 16'h0007,
		opMovi  = 16'h0008,
		opPop   = 16'h0009,
		opPush  = 16'h000B,
		opAdd   = 16'h000C,
		opAdc   = 16'h000D,
		opSub   = 16'h000E,
		opSuc   = 16'h000F,
		opCmp   = 16'h0014,
		opAnd   = 16'h0015,
		opInv   = 16'h0016,
		opOr    = 16'h0018,
		opShl   = 16'h0019,
		opShr   = 16'h001A,
		opXor   = 16'h001B,
		opTest  = 16'h001C,
		opCall  = 16'h001E,
		opRet   = 16'h001F,
		opJc    = 16'h0021,
		opJnc   = 16'h0022,
		opJz    = 16'h0023,
		opJnz   = 16'h0024,
		opJo    = 16'h0025,
		opJno   = 16'h0026,
		opSta   = 16'h002A, // par1 reg, par2 address
		opLda   = 16'h002B, // par1 reg, par2 address
		opJmp   = 16'h0031,
		opPutc  = 16'h00BF, // emit word at par1
		opHalt  = 16'h00FF
	} opcodeT;

endpackage

//--- memIf.sv
interface memIf import isaPkg::*; ();

	addrT addr;
	wordT wdata;
	logic we;    // one-cycle write strobe
	wordT rdata; // valid the cycle after addr

	modport ctrl (
		output addr,
		output wdata,
		output we,
		input  rdata
	);

	modport mem (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);

endinterface

//--- progMem.sv
`include "cpu_macros.svh"

module progMem
	import isaPkg::*;
(
	input  logic clk,
	input  logic loadEn,
	input  addrT loadAddr,
	input  wordT loadData,
	input  addrT fetchAddr,
	output wordT opcodeWord,
	output wordT par1Word,
	output wordT par2Word,
	memIf.mem    dataPort
);

	wordT mem [`CPU_MEM_DEPTH];
	addrT fetchAddr1;
	addrT fetchAddr2;

	// instruction words may straddle the end of memory
	assign fetchAddr1 = fetchAddr + addrT'(1);
	assign fetchAddr2 = fetchAddr + addrT'(2);

	always_ff @(posedge clk) begin
		if (loadEn) begin
			mem[loadAddr] <= loadData; // load port wins
		end else if (dataPort.we) begin
			mem[dataPort.addr] <= dataPort.wdata;
		end
	end

	always_ff @(posedge clk) begin
		opcodeWord <= mem[fetchAddr];
		par1Word <= mem[fetchAddr1];
		par2Word <= mem[fetchAddr2];
		dataPort.rdata <= mem[dataPort.addr];
	end

	// program loading only happens while the core is stopped
	loadDataCollision: assert property (@(posedge clk) !(loadEn && dataPort.we))
		else $error("load port write collided with a data write");

endmodule

//--- regFile.sv
module regFile
	import isaPkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  regSelT rdSelA,
	input  regSelT rdSelB,
	output wordT   rdDataA,
	output wordT   rdDataB,
	input  logic   wrEn,
	input  regSelT wrSel,
	input  wordT   wrData
);

	localparam int NumRegs = 4;

	wordT regs [NumRegs]; // ax, bx, cx, dx

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	assign rdDataA = regs[rdSelA];
	assign rdDataB = regs[rdSelB];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f --top-module tbCpu
./obj_dir/VtbCpu | tee sim.log
if grep -q "Result: FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

//--- sources.f
+incdir+.
isaPkg.sv
corePkg.sv
memIf.sv
progMem.sv
regFile.sv
alu.sv
controlUnit.sv
cpuTop.sv
tbCpu.sv

//--- cpuTests.svh
	localparam wordT Ax = 16'd0;
	localparam wordT Bx = 16'd1;
	localparam wordT Cx = 16'd2;
	localparam wordT Dx = 16'd3;
	localparam wordT FlagAddr = 16'h0300;
	localparam wordT ResultAddr = 16'h0301;
	localparam wordT MemBase = 16'h0310;
	localparam wordT MemCopy = 16'h0320;
	localparam wordT LoopAddr = 16'h0330;
	localparam wordT HoldAddr = 16'h0340;
	localparam wordT StackOut = 16'h0350;

	function automatic int instrLen(input opcodeT op);
		case (op)
			opNop, opRet, opHalt: return 1;
			opMovi, opLda, opSta: return 3;
			default: return 2;
		endcase
	endfunction

	function automatic wordT rr(input wordT dst, input wordT src);
		return (dst << 2) | src; // par1 of register forms
	endfunction

	task automatic clearProgram();
		prog.delete();
		expQ.delete();
	endtask

	task automatic asmInstr(input opcodeT op, input wordT p1 = 0, input wordT p2 = 0);
		int len;
		len = instrLen(op);
		prog.push_back(wordT'(op));
		if (len > 1) begin
			prog.push_back(p1);
		end
		if (len > 2) begin
			prog.push_back(p2);
		end
	endtask

	task automatic storeEmit(input wordT r, input wordT addr);
		asmInstr(opSta, r, addr);
		asmInstr(opPutc, addr);
	endtask

	task automatic setPair(input wordT a, input wordT b);
		asmInstr(opMovi, Ax, a);
		asmInstr(opMovi, Bx, b);
	endtask

	// cx holds takenVal only on a taken jump, so the emitted word equals the flag
	task automatic emitFlag(input opcodeT jumpOp, input logic takenVal, input logic flagVal);
		int patch;
		asmInstr(opMovi, Cx, {15'b0, takenVal});
		patch = prog.size() + 1;
		asmInstr(jumpOp, 0);
		asmInstr(opMovi, Cx, {15'b0, !takenVal});
		prog[patch] = wordT'(prog.size()); // jump lands on the store
		storeEmit(Cx, FlagAddr);
		expQ.push_back({15'b0, flagVal});
	endtask

	task automatic predictArith(input opcodeT op, input wordT a, input wordT b,
		inout logic carry, output wordT res, output logic zero, output logic ovf);
		int u;
		int s;
		int cin;
		cin = (op == opAdc || op == opSuc) ? int'(carry) : 0;
		if (op == opAdd || op == opAdc) begin
			u = int'(a) + int'(b) + cin;
			s = int'($signed(a)) + int'($signed(b)) + cin;
			carry = (u > 65535);
		end else begin
			u = int'(a) - int'(b) - cin;
			s = int'($signed(a)) - int'($signed(b)) - cin;
			carry = (u < 0); // borrow
		end
		res = u[15:0];
		zero = (res == 16'h0000);
		ovf = (s > 32767) || (s < -32768);
	endtask

	task automatic arithFlags();
		opcodeT ops [5];
		wordT a;
		wordT b;
		wordT res;
		logic c;
		logic z;
		logic o;
		int round;
		int i;
		ops = '{opAdd, opAdc, opSub, opSuc, opCmp};
		for (round = 0; round < 5; round++) begin
			clearProgram();
			c = 1'b0; // flags clear after reset
			case (round)
				0: begin
					a = 16'hFFFF;
					b = 16'h0001;
				end
				1: begin
					a = 16'h7FFF;
					b = 16'h7FFF;
				end
				default: begin
					a = wordT'($random(seed));
					b = wordT'($random(seed));
				end
			endcase
			for (i = 0; i < 5; i++) begin
				setPair(a, b);
				asmInstr(ops[i], rr(Ax, Bx));
				predictArith(ops[i], a, b, c, res, z, o);
				storeEmit(Ax, ResultAddr);
				expQ.push_back((ops[i] == opCmp) ? a : res); // compare writes nothing back
				if (i % 2 == 0) begin
					emitFlag(opJc, 1'b1, c);
					emitFlag(opJz, 1'b1, z);
					emitFlag(opJo, 1'b1, o);
				end else begin
					emitFlag(opJnc, 1'b0, c);
					emitFlag(opJnz, 1'b0, z);
					emitFlag(opJno, 1'b0, o);
				end
			end
			asmInstr(opHalt);
			runAndCompare($sformatf("arith round %0d", round));
		end
	endtask

	task automatic logicShifts();
		wordT a;
		wordT b;
		a = wordT'($random(seed));
		b = wordT'($random(seed));
		clearProgram();
		setPair(16'h0000, 16'h0001);
		asmInstr(opCmp, rr(Ax, Bx)); // borrow leaves carry set
		setPair(a, b);
		asmInstr(opAnd, rr(Ax, Bx));
		storeEmit(Ax, ResultAddr);
		expQ.push_back(a & b);
		setPair(a, b);
		asmInstr(opOr, rr(Ax, Bx));
		storeEmit(Ax, ResultAddr);
		expQ.push_back(a | b);
		setPair(a, b);
		asmInstr(opXor, rr(Ax, Bx));
		storeEmit(Ax, ResultAddr);
		expQ.push_back(a ^ b);
		setPair(a, b);
		asmInstr(opInv, Ax);
		storeEmit(Ax, ResultAddr);
		expQ.push_back(~a);
		setPair(a, b);
		asmInstr(opShl, Bx);
		storeEmit(Bx, ResultAddr);
		expQ.push_back(b << 1);
		setPair(a, b);
		asmInstr(opShr, Bx);
		storeEmit(Bx, ResultAddr);
		expQ.push_back(b >> 1);
		asmInstr(opMovrr, rr(Dx, Ax));
		storeEmit(Dx, ResultAddr);
		expQ.push_back(a);
		emitFlag(opJc, 1'b1, 1'b1); // logic ops kept the carry
		setPair(a, a);
		asmInstr(opTest, rr(Ax, Bx));
		emitFlag(opJz, 1'b1, 1'b1);
		setPair(a, a ^ 16'h0100);
		asmInstr(opTest, rr(Ax, Bx));
		emitFlag(opJnz, 1'b0, 1'b0);
		asmInstr(opHalt);
		runAndCompare("logic and shifts");
	endtask

	task automatic memoryRoundTrip();
		wordT v [4];
		int r;
		clearProgram();
		for (r = 0; r < 4; r++) begin
			v[r] = wordT'($random(seed));
			asmInstr(opMovi, wordT'(r), v[r]);
		end
		for (r = 0; r < 4; r++) begin
			asmInstr(opSta, wordT'(r), MemBase + wordT'(r));
		end
		for (r = 0; r < 4; r++) begin
			asmInstr(opLda, wordT'(3 - r), MemBase + wordT'(r)); // reversed registers
		end
		for (r = 0; r < 4; r++) begin
			storeEmit(wordT'(3 - r), MemCopy + wordT'(r));
			expQ.push_back(v[r]);
		end
		asmInstr(opHalt);
		runAndCompare("memory");
	endtask

	task automatic countdownLoop();
		int n;
		int k;
		wordT top;
		n = 3 + ($random(seed) & 7);
		clearProgram();
		setPair(wordT'(n), 16'd1);
		top = wordT'(prog.size());
		storeEmit(Ax, LoopAddr);
		asmInstr(opSub, rr(Ax, Bx));
		asmInstr(opJnz, top);
		asmInstr(opHalt);
		for (k = n; k > 0; k--) begin
			expQ.push_back(wordT'(k));
		end
		runAndCompare($sformatf("countdown from %0d", n));
	endtask

	task automatic stackCalls();
		wordT v [5];
		int r;
		int patch;
		clearProgram();
		for (r = 0; r < 5; r++) begin
			v[r] = wordT'($random(seed));
		end
		for (r = 0; r < 3; r++) begin
			asmInstr(opMovi, wordT'(r), v[r]);
		end
		for (r = 0; r < 3; r++) begin
			asmInstr(opPush, wordT'(r));
		end
		for (r = 0; r < 3; r++) begin
			asmInstr(opPop, wordT'(r)); // ax gets the last push
		end
		for (r = 0; r < 3; r++) begin
			storeEmit(wordT'(r), StackOut + wordT'(r));
			expQ.push_back(v[2 - r]);
		end
		patch = prog.size() + 1;
		asmInstr(opCall, 0);
		asmInstr(opMovi, Dx, v[4]);
		storeEmit(Dx, StackOut + 16'd4);
		asmInstr(opHalt);
		prog[patch] = wordT'(prog.size()); // subroutine after the halt
		asmInstr(opMovi, Dx, v[3]);
		storeEmit(Dx, StackOut + 16'd3);
		asmInstr(opRet);
		expQ.push_back(v[3]);
		expQ.push_back(v[4]);
		runAndCompare("stack and call");
	endtask

	task automatic haltHold();
		wordT v;
		int patch;
		int cyc;
		v = wordT'($random(seed));
		clearProgram();
		prog.push_back(16'h0077); // unused opcode, one-word NOP
		asmInstr(opNop);
		asmInstr(opMovi, Ax, v);
		patch = prog.size() + 1;
		asmInstr(opJmp, 0);
		asmInstr(opPutc, HoldAddr); // jumped over
		prog[patch] = wordT'(prog.size());
		storeEmit(Ax, HoldAddr);
		asmInstr(opHalt);
		asmInstr(opPutc, HoldAddr); // never reached
		expQ.push_back(v);
		runAndCompare("halt");
		@(posedge clk);
		#1 run = 1'b1;
		for (cyc = 0; cyc < 40; cyc++) begin
			@(negedge clk);
			checkValue("hold outValid", 16'd0, wordT'(outValid));
			checkValue("hold halted", 16'd1, wordT'(halted));
		end
		@(posedge clk);
		#1 run = 1'b0;
	endtask

//--- tbCpu.sv
module tbCpu import isaPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MaxCycles = 4000; // per program

	logic clk;
	logic arstN;
	logic loadEn;
	addrT loadAddr;
	wordT loadData;
	logic run;
	logic halted;
	wordT outData;
	logic outValid;

	wordT prog [$]; // program image, word 0 at address 0
	wordT expQ [$];
	wordT outQ [$]; // words seen with outValid
	int errors;
	int checks;
	integer seed;

	cpuTop i_dut (
		.clk      (clk),
		.arstN    (arstN),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.run      (run),
		.halted   (halted),
		.outData  (outData),
		.outValid (outValid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic checkValue(input string name, input wordT expected, input wordT actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic applyReset();
		@(posedge clk);
		#1 arstN = 1'b0;
		repeat (3) @(posedge clk);
		#1 arstN = 1'b1;
	endtask

	task automatic loadProgram();
		int i;
		for (i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			#1;
			loadEn = 1'b1;
			loadAddr = addrT'(i);
			loadData = prog[i];
		end
		@(posedge clk);
		#1 loadEn = 1'b0;
	endtask

	// outValid is a one-cycle pulse, sampled at every falling edge
	task automatic runProgram(input string name);
		int cycles;
		outQ.delete();
		cycles = 0;
		@(posedge clk);
		#1 run = 1'b1;
		while (!halted && cycles < MaxCycles) begin
			@(negedge clk);
			if (outValid) begin
				outQ.push_back(outData);
			end
			cycles++;
		end
		if (!halted) begin
			errors++;
			$display("Error: %s program did not halt within %0d cycles", name, MaxCycles);
		end
		@(posedge clk);
		#1 run = 1'b0;
	endtask

	task automatic checkOutputs(input string name);
		int i;
		checkValue({name, " output count"}, wordT'(expQ.size()), wordT'(outQ.size()));
		for (i = 0; i < expQ.size() && i < outQ.size(); i++) begin
			checkValue($sformatf("%s output %0d", name, i), expQ[i], outQ[i]);
		end
	endtask

	task automatic runAndCompare(input string name);
		applyReset(); // pc back to 0, stack empty
		loadProgram();
		runProgram(name);
		checkOutputs(name);
	endtask

	`include "cpuTests.svh"

	initial begin
		arstN = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		errors = 0;
		checks = 0;
		seed = 32'hec24d048;
		arithFlags();
		logicShifts();
		memoryRoundTrip();
		countdownLoop();
		stackCalls();
		haltHold();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
